//--- fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Rolling request tag, wraps at 16
`define FETCH_TAG_WIDTH 4

// One word per line, index taken from pc bits 5:2
`define ICACHE_LINES 16

// Program counter after reset
`define FETCH_RESET_PC 32'h0000_0000

// Opcode field of an instruction word
`define OPCODE_MSB 31
`define OPCODE_LSB 26

// Cycles a wait loop may spin before it gives up
`define FETCH_TIMEOUT 200

`endif

//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

	// Request side of the memory bus
	// The level stays high with a stable address until ready
	typedef struct packed {
		logic        req;
		logic [31:0] addr;
	} bus_req_t;

	// Response side, ready is a single-cycle pulse with data
	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire

//--- fetch_pkg.sv
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

	typedef logic [`FETCH_TAG_WIDTH-1:0] fetch_tag_t;

	typedef enum logic [1:0] {
		ST_ISSUE,
		ST_WAIT_REPLY,
		ST_WAIT_BRANCH
	} fetch_state_e;

	// Only jump and conditional branch matter to fetch
	typedef enum logic [5:0] {
		OP_PLAIN  = 6'd0,
		OP_JUMP   = 6'd2,
		OP_BRANCH = 6'd4
	} opcode_e;

	// Request from the pc sequencer to the cache
	typedef struct packed {
		fetch_tag_t  tag;
		logic [31:0] pc;
	} cache_req_t;

	// Cache reply, tag echoes the request it answers
	typedef struct packed {
		fetch_tag_t  tag;
		logic [31:0] instr;
	} cache_rsp_t;

	typedef struct packed {
		logic        valid;
		fetch_tag_t  tag;
		logic [31:0] instr;
		logic [31:0] pc;
	} fetch_out_t;

	// Back end reports the tag of a resolved branch and where to go
	typedef struct packed {
		fetch_tag_t  tag;
		logic [31:0] next_pc;
	} branch_resolve_t;

endpackage

`default_nettype wire

//--- pc_sequencer.sv
`default_nettype none

`include "fetch_consts.svh"

module pc_sequencer (
	input  wire logic           i_clock,
	input  wire logic           i_reset,
	input  wire logic           i_next_tag,
	input  wire logic           i_step,
	input  wire logic           i_redirect,
	input  wire logic [31:0]    i_redirect_pc,
	output fetch_pkg::cache_req_t o_req
);
	import fetch_pkg::*;

	cache_req_t req_q;
	fetch_tag_t tag_plus_one;
	logic [31:0] pc_plus_four;

	assign tag_plus_one = req_q.tag + 1'b1;
	assign pc_plus_four = req_q.pc + 32'd4;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			req_q.tag <= '0;
			req_q.pc <= `FETCH_RESET_PC;
		end else begin
			// Tag wraps naturally at its width
			if (i_next_tag) begin
				req_q.tag <= tag_plus_one;
			end

			// Branch target wins over the sequential step
			if (i_redirect) begin
				req_q.pc <= i_redirect_pc;
			end else if (i_step) begin
				req_q.pc <= pc_plus_four;
			end
		end
	end

	// Tag and pc change together on the same edge
	assign o_req = req_q;

endmodule

`default_nettype wire

//--- icache.sv
`default_nettype none

`include "fetch_consts.svh"

module icache (
	input  wire logic                  i_clock,
	input  wire logic                  i_reset,
	input  wire fetch_pkg::cache_req_t i_req,
	output fetch_pkg::cache_rsp_t      o_rsp,
	output bus_pkg::bus_req_t          o_bus,
	input  wire bus_pkg::bus_rsp_t     i_bus
);
	import fetch_pkg::*;

	localparam int INDEX_BITS = $clog2(`ICACHE_LINES);
	localparam int ATAG_BITS = 30 - INDEX_BITS;

	// Line storage
	logic [`ICACHE_LINES-1:0] line_valid;
	logic [ATAG_BITS-1:0] line_atag [`ICACHE_LINES];
	logic [31:0] line_data [`ICACHE_LINES];

	// Tag of the last request taken in
	fetch_tag_t last_tag;

	// Reply registers
	fetch_tag_t rsp_tag;
	logic [31:0] rsp_instr;

	// Bus request registers
	logic bus_req_q;
	logic [31:0] bus_addr_q;

	logic [INDEX_BITS-1:0] req_index;
	logic [ATAG_BITS-1:0] req_atag;
	logic [INDEX_BITS-1:0] fill_index;
	logic [ATAG_BITS-1:0] fill_atag;
	logic new_req;
	logic hit;
	logic fill_done;

	assign req_index = i_req.pc[INDEX_BITS+1:2];
	assign req_atag = i_req.pc[31:INDEX_BITS+2];

	// A fill writes the line its bus address points at
	assign fill_index = bus_addr_q[INDEX_BITS+1:2];
	assign fill_atag = bus_addr_q[31:INDEX_BITS+2];

	// A changed tag marks a new request, ignored while a fill runs
	assign new_req = !bus_req_q && (i_req.tag != last_tag);
	assign hit = line_valid[req_index] && (line_atag[req_index] == req_atag);
	assign fill_done = bus_req_q && i_bus.ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			last_tag <= '0;
			rsp_tag <= '0;
			bus_req_q <= 1'b0;
			line_valid <= '0;
		end else begin
			if (new_req) begin
				last_tag <= i_req.tag;
				if (hit) begin
					rsp_tag <= i_req.tag;
				end else begin
					bus_req_q <= 1'b1;
				end
			end

			// Request drops in the cycle after ready
			if (fill_done) begin
				bus_req_q <= 1'b0;
				line_valid[fill_index] <= 1'b1;
				rsp_tag <= last_tag;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (new_req) begin
			if (hit) begin
				rsp_instr <= line_data[req_index];
			end else begin
				bus_addr_q <= i_req.pc;
			end
		end

		// Filled word goes to the line and straight to the reply
		if (fill_done) begin
			line_atag[fill_index] <= fill_atag;
			line_data[fill_index] <= i_bus.rdata;
			rsp_instr <= i_bus.rdata;
		end
	end

	assign o_rsp = '{tag: rsp_tag, instr: rsp_instr};
	assign o_bus = '{req: bus_req_q, addr: bus_addr_q};

endmodule

`default_nettype wire

//--- fetch_control.sv
`default_nettype none

`include "fetch_consts.svh"

module fetch_control (
	input  wire logic                       i_clock,
	input  wire logic                       i_reset,
	input  wire logic                       i_stall,
	input  wire fetch_pkg::cache_req_t      i_req,
	input  wire fetch_pkg::cache_rsp_t      i_rsp,
	input  wire fetch_pkg::branch_resolve_t i_resolve,
	output logic                            o_next_tag,
	output logic                            o_step,
	output logic                            o_redirect,
	output logic [31:0]                     o_redirect_pc,
	output fetch_pkg::fetch_out_t           o_fetch
);
	import fetch_pkg::*;

	fetch_state_e state;
	opcode_e opcode;
	logic is_branch;
	logic reply_current;
	logic accept;
	logic resolved;

	// Jump/branch check on the returned word
	assign opcode = opcode_e'(i_rsp.instr[`OPCODE_MSB:`OPCODE_LSB]);
	assign is_branch = (opcode == OP_JUMP) || (opcode == OP_BRANCH);

	// While a tag command is in flight the old tags still match,
	// and that reply was already delivered
	assign reply_current = (i_rsp.tag == i_req.tag) && !o_next_tag;
	assign accept = (state == ST_WAIT_REPLY) && reply_current && !i_stall;

	// Back end names the branch we are holding for
	assign resolved = (state == ST_WAIT_BRANCH) && (i_resolve.tag == o_fetch.tag);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_ISSUE;
			o_next_tag <= 1'b0;
			o_step <= 1'b0;
			o_redirect <= 1'b0;
			o_fetch <= '0;
		end else begin
			// Commands and valid are single-cycle pulses
			o_next_tag <= 1'b0;
			o_step <= 1'b0;
			o_redirect <= 1'b0;
			o_fetch.valid <= 1'b0;

			case (state)
				ST_ISSUE: begin
					if (!i_stall) begin
						o_next_tag <= 1'b1;
						state <= ST_WAIT_REPLY;
					end
				end

				ST_WAIT_REPLY: begin
					if (accept) begin
						o_fetch.valid <= 1'b1;
						o_fetch.tag <= i_rsp.tag;
						o_fetch.instr <= i_rsp.instr;
						o_fetch.pc <= i_req.pc;
						o_step <= 1'b1;

						// Hold here until the branch outcome is known
						if (is_branch) begin
							state <= ST_WAIT_BRANCH;
						end else begin
							o_next_tag <= 1'b1;
						end
					end
				end

				ST_WAIT_BRANCH: begin
					if (resolved) begin
						o_redirect <= 1'b1;
						state <= ST_ISSUE;
					end
				end

				default: begin
					state <= ST_ISSUE;
				end
			endcase
		end
	end

	// Target travels with the redirect pulse
	always_ff @(posedge i_clock) begin
		if (resolved) begin
			o_redirect_pc <= i_resolve.next_pc;
		end
	end

endmodule

`default_nettype wire

//--- fetch_top.sv
`default_nettype none

module fetch_top (
	input  wire logic                       i_clock,
	input  wire logic                       i_reset,
	input  wire logic                       i_stall,
	input  wire fetch_pkg::branch_resolve_t i_resolve,
	output bus_pkg::bus_req_t               o_bus,
	input  wire bus_pkg::bus_rsp_t          i_bus,
	output fetch_pkg::fetch_out_t           o_fetch
);
	import fetch_pkg::*;

	cache_req_t cache_req;
	cache_rsp_t cache_rsp;

	// Commands from the FSM to the sequencer
	logic next_tag;
	logic step;
	logic redirect;
	logic [31:0] redirect_pc;

	pc_sequencer pc_sequencer_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_next_tag(next_tag),
		.i_step(step),
		.i_redirect(redirect),
		.i_redirect_pc(redirect_pc),
		.o_req(cache_req)
	);

	icache icache_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(cache_req),
		.o_rsp(cache_rsp),
		.o_bus(o_bus),
		.i_bus(i_bus)
	);

	fetch_control fetch_control_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(i_stall),
		.i_req(cache_req),
		.i_rsp(cache_rsp),
		.i_resolve(i_resolve),
		.o_next_tag(next_tag),
		.o_step(step),
		.o_redirect(redirect),
		.o_redirect_pc(redirect_pc),
		.o_fetch(o_fetch)
	);

endmodule

`default_nettype wire

//--- fetch_props.sv
`default_nettype none

`include "fetch_consts.svh"

module fetch_props (
	input wire logic                       i_clock,
	input wire logic                       i_reset,
	input wire logic                       i_stall,
	input wire fetch_pkg::branch_resolve_t i_resolve,
	input wire bus_pkg::bus_req_t          i_bus_req,
	input wire bus_pkg::bus_rsp_t          i_bus_rsp,
	input wire fetch_pkg::fetch_out_t      i_fetch
);
	import fetch_pkg::*;

	int fail_count = 0;

	// History of the last delivered instruction
	logic seen;
	fetch_tag_t last_tag;
	logic [31:0] last_pc;

	// Set while a delivered jump or branch waits for its outcome
	logic holding;
	logic resolve_seen;
	logic [31:0] held_target;
	logic out_branch;

	// Opcode 2 is a jump, 4 a conditional branch
	assign out_branch = (i_fetch.instr[`OPCODE_MSB:`OPCODE_LSB] == 6'd2) ||
		(i_fetch.instr[`OPCODE_MSB:`OPCODE_LSB] == 6'd4);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			seen <= 1'b0;
			holding <= 1'b0;
			resolve_seen <= 1'b0;
		end else if (i_fetch.valid) begin
			seen <= 1'b1;
			last_tag <= i_fetch.tag;
			last_pc <= i_fetch.pc;
			holding <= out_branch;
			resolve_seen <= 1'b0;
		end else if (holding && !resolve_seen && (i_resolve.tag == i_fetch.tag)) begin
			resolve_seen <= 1'b1;
			held_target <= i_resolve.next_pc;
		end
	end

	a_reset_idle: assert property (@(posedge i_clock)
		i_reset |=> (i_fetch == '0) && !i_bus_req.req)
		else begin
			fail_count = fail_count + 1;
			$error("error o_fetch %h o_bus.req %h expected 0 after reset",
				i_fetch, i_bus_req.req);
		end

	// Request level and address hold until ready
	a_bus_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_req.req && !i_bus_rsp.ready |=> i_bus_req.req && $stable(i_bus_req.addr))
		else begin
			fail_count = fail_count + 1;
			$error("bus request dropped or address changed before ready");
		end

	a_bus_drop: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_req.req && i_bus_rsp.ready |=> !i_bus_req.req)
		else begin
			fail_count = fail_count + 1;
			$error("bus request still high in the cycle after ready");
		end

	a_stall: assert property (@(posedge i_clock) disable iff (i_reset)
		i_stall |=> !i_fetch.valid)
		else begin
			fail_count = fail_count + 1;
			$error("instruction delivered while stall was high");
		end

	a_tag_step: assert property (@(posedge i_clock) disable iff (i_reset)
		i_fetch.valid && seen |-> i_fetch.tag == fetch_tag_t'(last_tag + 1'b1))
		else begin
			fail_count = fail_count + 1;
			$error("error o_fetch.tag %h expected %h", i_fetch.tag,
				fetch_tag_t'(last_tag + 1'b1));
		end

	a_pc_step: assert property (@(posedge i_clock) disable iff (i_reset)
		i_fetch.valid && seen && !holding |-> i_fetch.pc == last_pc + 32'd4)
		else begin
			fail_count = fail_count + 1;
			$error("error o_fetch.pc %h expected %h", i_fetch.pc, last_pc + 32'd4);
		end

	a_branch_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		i_fetch.valid && holding |-> resolve_seen)
		else begin
			fail_count = fail_count + 1;
			$error("instruction delivered before the pending branch was resolved");
		end

	a_branch_target: assert property (@(posedge i_clock) disable iff (i_reset)
		i_fetch.valid && holding && resolve_seen |-> i_fetch.pc == held_target)
		else begin
			fail_count = fail_count + 1;
			$error("error o_fetch.pc %h expected %h", i_fetch.pc, held_target);
		end

endmodule

bind fetch_top fetch_props props_i (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_stall(i_stall),
	.i_resolve(i_resolve),
	.i_bus_req(o_bus),
	.i_bus_rsp(i_bus),
	.i_fetch(o_fetch)
);

`default_nettype wire

//--- fetch_tb.sv
`default_nettype none

`include "fetch_consts.svh"

module fetch_tb;
	import fetch_pkg::*;
	import bus_pkg::*;

	logic i_clock;
	logic i_reset;
	logic i_stall;
	branch_resolve_t i_resolve = '0;
	bus_req_t o_bus;
	bus_rsp_t i_bus = '0;
	fetch_out_t o_fetch;

	int errors;
	int timeouts;
	logic timed_out;
	logic [31:0] jump_target;

	// Memory model state
	logic mem_busy = 1'b0;
	int mem_wait;

	// Back-end model state
	logic br_pending = 1'b0;
	logic resolving = 1'b0;
	int br_wait;
	fetch_tag_t br_tag;
	logic [31:0] br_target;

	// Expected pc model
	logic [31:0] exp_pc;
	logic expect_hits = 1'b0;

	fetch_top dut_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(i_stall),
		.i_resolve(i_resolve),
		.o_bus(o_bus),
		.i_bus(i_bus),
		.o_fetch(o_fetch)
	);

	// Low 26 bits hold the word address, opcode 2 at 0x40 and 4 at 0x80
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [5:0] opcode;
		opcode = 6'd0;
		if (addr == 32'h40) begin
			opcode = 6'd2;
		end else if (addr == 32'h80) begin
			opcode = 6'd4;
		end
		return {opcode, addr[27:2]};
	endfunction

	function automatic logic is_branch_word(input logic [31:0] word);
		return (word[`OPCODE_MSB:`OPCODE_LSB] == 6'd2) ||
			(word[`OPCODE_MSB:`OPCODE_LSB] == 6'd4);
	endfunction

	function automatic logic [31:0] resolve_target(input logic [31:0] pc);
		if (pc == 32'h40) begin
			return jump_target;
		end
		return 32'h20;
	endfunction

	initial begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	// Memory answers after 0 to 5 idle cycles with a one-cycle ready
	always @(negedge i_clock) begin
		if (i_reset) begin
			i_bus = '0;
			mem_busy = 1'b0;
		end else if (i_bus.ready) begin
			i_bus.ready = 1'b0;
		end else if (mem_busy) begin
			if (mem_wait == 0) begin
				i_bus.ready = 1'b1;
				i_bus.rdata = mem_word(o_bus.addr);
				mem_busy = 1'b0;
			end else begin
				mem_wait = mem_wait - 1;
			end
		end else if (o_bus.req) begin
			// A miss always fetches the word the model expects next
			assert (o_bus.addr == exp_pc) else begin
				errors++;
				$display("error o_bus.addr %h expected %h", o_bus.addr, exp_pc);
			end
			mem_busy = 1'b1;
			mem_wait = $urandom % 6;
		end
	end

	// Back end parks the resolve tag away from the delivered one
	always @(negedge i_clock) begin
		if (i_reset) begin
			br_pending = 1'b0;
			resolving = 1'b0;
			i_resolve = '{tag: fetch_tag_t'(8), next_pc: 32'h0};
		end else begin
			if (resolving && o_fetch.valid) begin
				resolving = 1'b0;
			end
			if (!resolving) begin
				if (br_pending) begin
					if (br_wait == 0) begin
						i_resolve = '{tag: br_tag, next_pc: br_target};
						resolving = 1'b1;
						br_pending = 1'b0;
					end else begin
						br_wait = br_wait - 1;
					end
				end else begin
					if (o_fetch.valid && is_branch_word(o_fetch.instr)) begin
						br_pending = 1'b1;
						br_tag = o_fetch.tag;
						br_target = resolve_target(o_fetch.pc);
						br_wait = $urandom % 6;
					end
					i_resolve.tag = o_fetch.tag + fetch_tag_t'(8);
				end
			end
		end
	end

	// Checks every delivery against the pc model and the memory contents
	always @(negedge i_clock) begin
		if (i_reset) begin
			exp_pc = `FETCH_RESET_PC;
			expect_hits = 1'b0;
		end else begin
			// Lines 0x20 to 0x3C are still filled after the branch
			if (expect_hits) begin
				assert (!o_bus.req) else begin
					errors++;
					$display("error o_bus.req %h expected %h", o_bus.req, 1'b0);
				end
			end
			if (o_fetch.valid) begin
				assert (o_fetch.pc == exp_pc) else begin
					errors++;
					$display("error o_fetch.pc %h expected %h", o_fetch.pc, exp_pc);
				end
				assert (o_fetch.instr == mem_word(exp_pc)) else begin
					errors++;
					$display("error o_fetch.instr %h expected %h", o_fetch.instr,
						mem_word(exp_pc));
				end
				if (exp_pc == 32'h80) begin
					expect_hits = 1'b1;
				end else if (exp_pc == 32'h3C) begin
					expect_hits = 1'b0;
				end
				if (is_branch_word(mem_word(exp_pc))) begin
					exp_pc = resolve_target(exp_pc);
				end else begin
					exp_pc = exp_pc + 32'd4;
				end
			end
		end
	end

	task automatic apply_reset();
		i_reset = 1'b1;
		i_stall = 1'b0;
		repeat (16) @(negedge i_clock);
		assert (!o_fetch.valid) else begin
			errors++;
			$display("error o_fetch.valid %h expected %h", o_fetch.valid, 1'b0);
		end
		assert (!o_bus.req) else begin
			errors++;
			$display("error o_bus.req %h expected %h", o_bus.req, 1'b0);
		end
		assert (o_fetch == '0) else begin
			errors++;
			$display("error o_fetch %h expected %h", o_fetch, fetch_out_t'(0));
		end
		i_reset = 1'b0;
	endtask

	// Waits for count deliveries, stalling a given percent of cycles
	task automatic run_deliveries(input int count, input int stall_pct);
		int got;
		int idle;
		got = 0;
		idle = 0;
		while (got < count && !timed_out) begin
			@(negedge i_clock);
			if (o_fetch.valid) begin
				got++;
				idle = 0;
			end else begin
				idle++;
			end
			i_stall = (stall_pct > 0) && (($urandom % 100) < stall_pct);
			if (idle > `FETCH_TIMEOUT) begin
				timed_out = 1'b1;
				timeouts++;
				$display("timed out waiting for a fetched instruction after %0d of %0d",
					got, count);
			end
		end
		i_stall = 1'b0;
	endtask

	initial begin
		void'($urandom(96));
		errors = 0;
		timeouts = 0;
		timed_out = 1'b0;
		jump_target = 32'h100;
		i_reset = 1'b1;
		i_stall = 1'b0;

		apply_reset();
		// Up to the jump at 0x40, then on from 0x100 under random stall
		run_deliveries(17, 0);
		if (!timed_out) begin
			run_deliveries(24, 30);
		end

		// Jump lands on the branch so 0x20 to 0x3C are refetched from the cache
		if (!timed_out) begin
			@(negedge i_clock);
			jump_target = 32'h80;
			apply_reset();
			run_deliveries(40, 0);
		end

		$display("run done: %0d model errors, %0d assertion failures, %0d timeouts",
			errors, dut_i.props_i.fail_count, timeouts);
		if (errors == 0 && dut_i.props_i.fail_count == 0 && timeouts == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
bus_pkg.sv
fetch_pkg.sv
pc_sequencer.sv
icache.sv
fetch_control.sv
fetch_top.sv
fetch_props.sv
fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_subsystem

export_include_dirs:
  - .

sources:
  - bus_pkg.sv
  - fetch_pkg.sv
  - pc_sequencer.sv
  - icache.sv
  - fetch_control.sv
  - fetch_top.sv
  - target: test
    files:
      - fetch_props.sv
      - fetch_tb.sv
